// File: l2c_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BEATS must equal 2**BEAT_W and TAG_W must fill the address above the index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package l2c_pkg;

	// Address split is tag | index | offset
	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 64;

	// One line is BEATS beats of DATA_W bits
	localparam int BEATS    = 4;
	localparam int BEAT_W   = 2;
	localparam int OFFSET_W = 5;

	// Set geometry
	localparam int NUM_SETS = 8;
	localparam int INDEX_W  = 3;
	localparam int TAG_W    = 24;

	// Associativity
	localparam int NUM_WAYS = 4;
	localparam int WAY_W    = 2;

	// Controller states
	localparam logic [2:0] ST_FREE   = 3'd0;
	// Tag compare on the latched address
	localparam logic [2:0] ST_CHECK  = 3'd1;
	// Line fill from memory
	localparam logic [2:0] ST_REFILL = 3'd2;
	// Burst back to the instruction client
	localparam logic [2:0] ST_RESP_I = 3'd3;
	// Burst back to the data client
	localparam logic [2:0] ST_RESP_D = 3'd4;
	// One cycle to drop every valid bit
	localparam logic [2:0] ST_FENCE  = 3'd5;

endpackage

`default_nettype wire

// File: l2c_way.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data appears the cycle after read_en and holds until the next one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module l2c_way (
	input  logic                         CLK,
	input  logic                         reset,
	input  logic [l2c_pkg::INDEX_W-1:0]  set_index,
	input  logic [l2c_pkg::TAG_W-1:0]    req_tag,
	input  logic                         read_en,
	input  logic [l2c_pkg::BEAT_W-1:0]   read_beat,
	input  logic                         refill_we,
	input  logic [l2c_pkg::BEAT_W-1:0]   refill_beat,
	input  logic [l2c_pkg::DATA_W-1:0]   refill_data,
	input  logic                         refill_last,
	input  logic                         fence_clear,
	input  logic                         victim,
	output logic                         hit,
	output logic                         valid_at_index,
	output logic [l2c_pkg::DATA_W-1:0]   rdata
);

	// One tag and one valid bit per set
	logic [l2c_pkg::TAG_W-1:0]    tag_mem [l2c_pkg::NUM_SETS];
	logic [l2c_pkg::NUM_SETS-1:0] valid_q;

	// Data indexed by {set, beat}
	logic [l2c_pkg::DATA_W-1:0]   data_mem [l2c_pkg::NUM_SETS * l2c_pkg::BEATS];

	assign valid_at_index = valid_q[set_index];
	assign hit            = valid_at_index && (tag_mem[set_index] == req_tag);

	// Line becomes valid only after its final beat lands
	always_ff @(posedge CLK) begin
		if (reset)
			valid_q <= '0;
		else if (fence_clear)
			valid_q <= '0;
		else if (refill_last && victim)
			valid_q[set_index] <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (refill_last && victim)
			tag_mem[set_index] <= req_tag;
	end

	// One beat written per memory transfer
	always_ff @(posedge CLK) begin
		if (refill_we && victim)
			data_mem[{set_index, refill_beat}] <= refill_data;
	end

	// Registered read, held while the client stalls
	always_ff @(posedge CLK) begin
		if (read_en)
			rdata <= data_mem[{set_index, read_beat}];
	end

	// Refill and fence come from different controller states
	a_last_vs_fence: assert property (@(posedge CLK) disable iff (reset)
		!(refill_last && fence_clear));

endmodule

`default_nettype wire

// File: l2c_victim_sel.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Choice is valid from the cycle after refill_start until the next one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module l2c_victim_sel (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic [l2c_pkg::NUM_WAYS-1:0]  valid_bits,
	input  logic                          refill_start,
	output logic [l2c_pkg::NUM_WAYS-1:0]  victim
);

	// Taps 16, 14, 13, 11
	localparam int              LFSR_W    = 16;
	localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

	logic [LFSR_W-1:0]            lfsr;
	logic [l2c_pkg::WAY_W-1:0]    free_way;
	logic [l2c_pkg::WAY_W-1:0]    pick;
	logic [l2c_pkg::NUM_WAYS-1:0] victim_next;

	// Free running, never allowed to reach zero
	always_ff @(posedge CLK) begin
		if (reset)
			lfsr <= 16'hACE1;
		else
			lfsr <= {lfsr[LFSR_W-2:0], ^(lfsr & LFSR_TAPS)};
	end

	// Lowest invalid way wins
	always_comb begin
		free_way = '0;
		for (int w = l2c_pkg::NUM_WAYS - 1; w >= 0; w--) begin
			if (!valid_bits[w])
				free_way = w[l2c_pkg::WAY_W-1:0];
		end
	end

	// Full set falls back to the LFSR
	always_comb begin
		pick = (&valid_bits) ? lfsr[l2c_pkg::WAY_W-1:0] : free_way;
		victim_next = '0;
		victim_next[pick] = 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (reset)
			victim <= {{(l2c_pkg::NUM_WAYS-1){1'b0}}, 1'b1};
		else if (refill_start)
			victim <= victim_next;
	end

	// Exactly one way is written during any refill
	a_victim_onehot: assert property (@(posedge CLK) disable iff (reset)
		$onehot(victim));

endmodule

`default_nettype wire

// File: l2c_hit_mux.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output data is zero when no way hits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module l2c_hit_mux (
	input  logic [l2c_pkg::NUM_WAYS-1:0]                      way_hit,
	input  logic [l2c_pkg::NUM_WAYS-1:0][l2c_pkg::DATA_W-1:0] way_rdata,
	output logic                                              any_hit,
	output logic [l2c_pkg::DATA_W-1:0]                        rdata
);

	assign any_hit = |way_hit;

	// AND-OR select, relies on a single hitting way
	always_comb begin
		rdata = '0;
		for (int w = 0; w < l2c_pkg::NUM_WAYS; w++) begin
			rdata = rdata | (way_rdata[w] & {l2c_pkg::DATA_W{way_hit[w]}});
		end
	end

	// A line is never cached in two ways of one set
	always_comb begin
		a_hit_onehot0: assert final ($onehot0(way_hit));
	end

endmodule

`default_nettype wire

// File: l2c_ctrl.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clients hold arvalid and araddr until arready, offset bits are ignored
// A fence waits for the free state and goes ahead of new requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module l2c_ctrl (
	input  logic                         CLK,
	input  logic                         reset,
	input  logic [l2c_pkg::ADDR_W-1:0]   il1_araddr,
	input  logic                         il1_arvalid,
	input  logic                         il1_rready,
	input  logic [l2c_pkg::ADDR_W-1:0]   dl1_araddr,
	input  logic                         dl1_arvalid,
	input  logic                         dl1_rready,
	input  logic                         l2c_fence,
	input  logic                         mem_arready,
	input  logic [l2c_pkg::DATA_W-1:0]   mem_rdata,
	input  logic                         mem_rlast,
	input  logic                         mem_rvalid,
	input  logic                         any_hit,
	output logic                         il1_arready,
	output logic                         il1_rvalid,
	output logic                         il1_rlast,
	output logic                         dl1_arready,
	output logic                         dl1_rvalid,
	output logic                         dl1_rlast,
	output logic [l2c_pkg::ADDR_W-1:0]   mem_araddr,
	output logic                         mem_arvalid,
	output logic                         mem_rready,
	output logic [l2c_pkg::INDEX_W-1:0]  set_index,
	output logic [l2c_pkg::TAG_W-1:0]    req_tag,
	output logic                         read_en,
	output logic [l2c_pkg::BEAT_W-1:0]   read_beat,
	output logic                         refill_we,
	output logic [l2c_pkg::BEAT_W-1:0]   refill_beat,
	output logic [l2c_pkg::DATA_W-1:0]   refill_data,
	output logic                         refill_last,
	output logic                         fence_clear,
	output logic                         refill_start
);

	logic [2:0] state;
	logic [2:0] state_next;

	// Line address of the request being served
	logic [l2c_pkg::ADDR_W-l2c_pkg::OFFSET_W-1:0] req_line;
	logic                                         serve_il1;
	logic                                         fence_pending;
	logic [l2c_pkg::BEAT_W-1:0]                   resp_beat;

	logic hit_go;
	logic resp_xfer;
	logic resp_last;

	assign set_index = req_line[l2c_pkg::INDEX_W-1:0];
	assign req_tag   = req_line[l2c_pkg::ADDR_W-l2c_pkg::OFFSET_W-1 -: l2c_pkg::TAG_W];

	// Tag check result in the check state
	assign hit_go       = (state == l2c_pkg::ST_CHECK) && any_hit;
	assign refill_start = (state == l2c_pkg::ST_CHECK) && !any_hit;
	assign fence_clear  = (state == l2c_pkg::ST_FENCE);

	// Request accepted in the same cycle the hit is seen
	assign il1_arready = hit_go && serve_il1;
	assign dl1_arready = hit_go && !serve_il1;

	// Only one client can hold rvalid at a time
	assign resp_xfer = (il1_rvalid && il1_rready) || (dl1_rvalid && dl1_rready);
	// Last beat when the counter is all ones
	assign resp_last = resp_xfer && (&resp_beat);
	assign il1_rlast = il1_rvalid && (&resp_beat);
	assign dl1_rlast = dl1_rvalid && (&resp_beat);

	// Beat 0 on the hit, next beat on every transfer but the last
	assign read_en   = hit_go || (resp_xfer && !(&resp_beat));
	assign read_beat = hit_go ? '0 : resp_beat + 1'b1;

	// Memory side of the refill
	assign mem_araddr  = {req_line, {l2c_pkg::OFFSET_W{1'b0}}};
	assign refill_we   = mem_rvalid && mem_rready;
	assign refill_last = refill_we && mem_rlast;
	assign refill_data = mem_rdata;

	always_comb begin
		state_next = state;
		case (state)
			l2c_pkg::ST_FREE: begin
				if (fence_pending)
					state_next = l2c_pkg::ST_FENCE;
				else if (il1_arvalid || dl1_arvalid)
					state_next = l2c_pkg::ST_CHECK;
			end
			l2c_pkg::ST_CHECK: begin
				if (!any_hit)
					state_next = l2c_pkg::ST_REFILL;
				else if (serve_il1)
					state_next = l2c_pkg::ST_RESP_I;
				else
					state_next = l2c_pkg::ST_RESP_D;
			end
			// Back to check, which hits on the fresh line
			l2c_pkg::ST_REFILL: if (refill_last) state_next = l2c_pkg::ST_CHECK;
			l2c_pkg::ST_RESP_I: if (resp_last) state_next = l2c_pkg::ST_FREE;
			l2c_pkg::ST_RESP_D: if (resp_last) state_next = l2c_pkg::ST_FREE;
			l2c_pkg::ST_FENCE:  state_next = l2c_pkg::ST_FREE;
			default:            state_next = l2c_pkg::ST_FREE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset)
			state <= l2c_pkg::ST_FREE;
		else
			state <= state_next;
	end

	// Winner latched on leaving the free state, instruction first
	always_ff @(posedge CLK) begin
		if (reset)
			serve_il1 <= 1'b0;
		else if (state == l2c_pkg::ST_FREE && state_next == l2c_pkg::ST_CHECK)
			serve_il1 <= il1_arvalid;
	end

	always_ff @(posedge CLK) begin
		if (state == l2c_pkg::ST_FREE && state_next == l2c_pkg::ST_CHECK)
			req_line <= il1_arvalid ? il1_araddr[l2c_pkg::ADDR_W-1:l2c_pkg::OFFSET_W]
			                        : dl1_araddr[l2c_pkg::ADDR_W-1:l2c_pkg::OFFSET_W];
	end

	// A pulse arriving during the fence cycle stays pending
	always_ff @(posedge CLK) begin
		if (reset)
			fence_pending <= 1'b0;
		else
			fence_pending <= l2c_fence || (fence_pending && !fence_clear);
	end

	// Response beat counter
	always_ff @(posedge CLK) begin
		if (reset)
			resp_beat <= '0;
		else if (hit_go)
			resp_beat <= '0;
		else if (resp_xfer)
			resp_beat <= resp_beat + 1'b1;
	end

	// rvalid rises one cycle after arready and drops after rlast
	always_ff @(posedge CLK) begin
		if (reset) begin
			il1_rvalid <= 1'b0;
			dl1_rvalid <= 1'b0;
		end else begin
			if (il1_arready)
				il1_rvalid <= 1'b1;
			else if (il1_rvalid && il1_rready && il1_rlast)
				il1_rvalid <= 1'b0;
			if (dl1_arready)
				dl1_rvalid <= 1'b1;
			else if (dl1_rvalid && dl1_rready && dl1_rlast)
				dl1_rvalid <= 1'b0;
		end
	end

	// Address request first, then accept beats until the last
	always_ff @(posedge CLK) begin
		if (reset) begin
			mem_arvalid <= 1'b0;
			mem_rready  <= 1'b0;
			refill_beat <= '0;
		end else begin
			if (refill_start)
				mem_arvalid <= 1'b1;
			else if (mem_arready)
				mem_arvalid <= 1'b0;
			if (mem_arvalid && mem_arready)
				mem_rready <= 1'b1;
			else if (refill_last)
				mem_rready <= 1'b0;
			if (refill_start)
				refill_beat <= '0;
			else if (refill_we)
				refill_beat <= refill_beat + 1'b1;
		end
	end

	// Memory request is not withdrawn before acceptance
	a_mem_ar_hold: assert property (@(posedge CLK) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid);

	// Response beats wait for the client
	a_il1_r_hold: assert property (@(posedge CLK) disable iff (reset)
		il1_rvalid && !il1_rready |=> il1_rvalid);
	a_dl1_r_hold: assert property (@(posedge CLK) disable iff (reset)
		dl1_rvalid && !dl1_rready |=> dl1_rvalid);

endmodule

`default_nettype wire

// File: l2_cache.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only L2, requests are whole line-aligned lines
// Both clients share one read data bus, only one is ever valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module l2_cache (
	input  logic                        CLK,
	input  logic                        reset,

	// Instruction client
	input  logic [l2c_pkg::ADDR_W-1:0]  il1_araddr,
	input  logic                        il1_arvalid,
	output logic                        il1_arready,
	output logic [l2c_pkg::DATA_W-1:0]  il1_rdata,
	output logic                        il1_rlast,
	output logic                        il1_rvalid,
	input  logic                        il1_rready,

	// Data client
	input  logic [l2c_pkg::ADDR_W-1:0]  dl1_araddr,
	input  logic                        dl1_arvalid,
	output logic                        dl1_arready,
	output logic [l2c_pkg::DATA_W-1:0]  dl1_rdata,
	output logic                        dl1_rlast,
	output logic                        dl1_rvalid,
	input  logic                        dl1_rready,

	// Memory read port
	output logic [l2c_pkg::ADDR_W-1:0]  mem_araddr,
	output logic                        mem_arvalid,
	input  logic                        mem_arready,
	input  logic [l2c_pkg::DATA_W-1:0]  mem_rdata,
	input  logic                        mem_rlast,
	input  logic                        mem_rvalid,
	output logic                        mem_rready,

	// Invalidate all lines
	input  logic                        l2c_fence
);

	// Controller to ways
	logic [l2c_pkg::INDEX_W-1:0]  set_index;
	logic [l2c_pkg::TAG_W-1:0]    req_tag;
	logic                         read_en;
	logic [l2c_pkg::BEAT_W-1:0]   read_beat;
	logic                         refill_we;
	logic [l2c_pkg::BEAT_W-1:0]   refill_beat;
	logic [l2c_pkg::DATA_W-1:0]   refill_data;
	logic                         refill_last;
	logic                         fence_clear;
	logic                         refill_start;

	// Per way results
	logic [l2c_pkg::NUM_WAYS-1:0]                      way_hit;
	logic [l2c_pkg::NUM_WAYS-1:0]                      way_valid;
	logic [l2c_pkg::NUM_WAYS-1:0]                      victim;
	logic [l2c_pkg::NUM_WAYS-1:0][l2c_pkg::DATA_W-1:0] way_rdata;

	logic                         any_hit;
	logic [l2c_pkg::DATA_W-1:0]   cache_rdata;

	l2c_ctrl u_ctrl (
		.CLK          (CLK),
		.reset        (reset),
		.il1_araddr   (il1_araddr),
		.il1_arvalid  (il1_arvalid),
		.il1_rready   (il1_rready),
		.dl1_araddr   (dl1_araddr),
		.dl1_arvalid  (dl1_arvalid),
		.dl1_rready   (dl1_rready),
		.l2c_fence    (l2c_fence),
		.mem_arready  (mem_arready),
		.mem_rdata    (mem_rdata),
		.mem_rlast    (mem_rlast),
		.mem_rvalid   (mem_rvalid),
		.any_hit      (any_hit),
		.il1_arready  (il1_arready),
		.il1_rvalid   (il1_rvalid),
		.il1_rlast    (il1_rlast),
		.dl1_arready  (dl1_arready),
		.dl1_rvalid   (dl1_rvalid),
		.dl1_rlast    (dl1_rlast),
		.mem_araddr   (mem_araddr),
		.mem_arvalid  (mem_arvalid),
		.mem_rready   (mem_rready),
		.set_index    (set_index),
		.req_tag      (req_tag),
		.read_en      (read_en),
		.read_beat    (read_beat),
		.refill_we    (refill_we),
		.refill_beat  (refill_beat),
		.refill_data  (refill_data),
		.refill_last  (refill_last),
		.fence_clear  (fence_clear),
		.refill_start (refill_start)
	);

	// One way per generate slot, each owns one victim bit
	for (genvar g = 0; g < l2c_pkg::NUM_WAYS; g++) begin : g_way
		l2c_way u_way (
			.CLK            (CLK),
			.reset          (reset),
			.set_index      (set_index),
			.req_tag        (req_tag),
			.read_en        (read_en),
			.read_beat      (read_beat),
			.refill_we      (refill_we),
			.refill_beat    (refill_beat),
			.refill_data    (refill_data),
			.refill_last    (refill_last),
			.fence_clear    (fence_clear),
			.victim         (victim[g]),
			.hit            (way_hit[g]),
			.valid_at_index (way_valid[g]),
			.rdata          (way_rdata[g])
		);
	end

	l2c_victim_sel u_victim_sel (
		.CLK          (CLK),
		.reset        (reset),
		.valid_bits   (way_valid),
		.refill_start (refill_start),
		.victim       (victim)
	);

	l2c_hit_mux u_hit_mux (
		.way_hit   (way_hit),
		.way_rdata (way_rdata),
		.any_hit   (any_hit),
		.rdata     (cache_rdata)
	);

	// Shared read data, qualified by each client's own rvalid
	assign il1_rdata = cache_rdata;
	assign dl1_rdata = cache_rdata;

endmodule

`default_nettype wire

// File: tb_l2_cache.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory contents never change, every beat must match expected_beat
// Run is cut off after NUM_REQS * 200 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_l2_cache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_REQS       = 39;
	localparam int TIMEOUT_CYCLES = NUM_REQS * 200;
	localparam logic [l2c_pkg::DATA_W-1:0] MEM_PATTERN = 64'h5A5A_C3C3_0F0F_9696;
	// Lines used by the directed steps, set 0 and set 1 and set 2
	localparam logic [l2c_pkg::ADDR_W-1:0] LINE_A = 32'h0000_1000;
	localparam logic [l2c_pkg::ADDR_W-1:0] LINE_B = 32'h0000_2020;
	localparam logic [l2c_pkg::ADDR_W-1:0] LINE_C = 32'h0000_3040;

	logic                        CLK;
	logic                        reset;
	logic [l2c_pkg::ADDR_W-1:0]  il1_araddr;
	logic                        il1_arvalid;
	logic                        il1_arready;
	logic [l2c_pkg::DATA_W-1:0]  il1_rdata;
	logic                        il1_rlast;
	logic                        il1_rvalid;
	logic                        il1_rready;
	logic [l2c_pkg::ADDR_W-1:0]  dl1_araddr;
	logic                        dl1_arvalid;
	logic                        dl1_arready;
	logic [l2c_pkg::DATA_W-1:0]  dl1_rdata;
	logic                        dl1_rlast;
	logic                        dl1_rvalid;
	logic                        dl1_rready;
	logic [l2c_pkg::ADDR_W-1:0]  mem_araddr;
	logic                        mem_arvalid;
	logic                        mem_arready;
	logic [l2c_pkg::DATA_W-1:0]  mem_rdata;
	logic                        mem_rlast;
	logic                        mem_rvalid;
	logic                        mem_rready;
	logic                        l2c_fence;

	integer seed = 32'h9526_edd0;
	int     cycle;
	int     data_errors;
	int     flow_errors;
	int     beats_checked;
	int     req_count;

	// Per port state, index 0 is the instruction port
	logic [l2c_pkg::ADDR_W-1:0]  cur_addr [2];
	int                          beat_cnt [2];
	int                          lines_done [2];
	bit                          held_stall [2];
	logic [l2c_pkg::DATA_W-1:0]  held_data [2];
	logic                        held_last [2];

	l2_cache dut_i (
		.CLK         (CLK),
		.reset       (reset),
		.il1_araddr  (il1_araddr),
		.il1_arvalid (il1_arvalid),
		.il1_arready (il1_arready),
		.il1_rdata   (il1_rdata),
		.il1_rlast   (il1_rlast),
		.il1_rvalid  (il1_rvalid),
		.il1_rready  (il1_rready),
		.dl1_araddr  (dl1_araddr),
		.dl1_arvalid (dl1_arvalid),
		.dl1_arready (dl1_arready),
		.dl1_rdata   (dl1_rdata),
		.dl1_rlast   (dl1_rlast),
		.dl1_rvalid  (dl1_rvalid),
		.dl1_rready  (dl1_rready),
		.mem_araddr  (mem_araddr),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rdata   (mem_rdata),
		.mem_rlast   (mem_rlast),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready),
		.l2c_fence   (l2c_fence)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	always @(posedge CLK) cycle++;

	// Line base plus byte offset of the beat, scrambled by a fixed pattern
	function automatic logic [l2c_pkg::DATA_W-1:0] expected_beat(
			input logic [l2c_pkg::ADDR_W-1:0] addr, input int beat);
		logic [l2c_pkg::DATA_W-1:0] line_base;
		line_base = {{(l2c_pkg::DATA_W-l2c_pkg::ADDR_W){1'b0}},
		             addr[l2c_pkg::ADDR_W-1:l2c_pkg::OFFSET_W], {l2c_pkg::OFFSET_W{1'b0}}};
		return (line_base + 64'(beat * 8)) ^ MEM_PATTERN;
	endfunction

	// Random back-pressure on both clients
	always @(posedge CLK) begin
		#2;
		il1_rready = ($random(seed) & 3) != 0;
		dl1_rready = ($random(seed) & 3) != 0;
	end

	// Memory model, accepts after a random delay then streams one line
	initial begin : memory_model
		logic [l2c_pkg::ADDR_W-1:0] mem_line;
		int delay;
		bit xfer;
		forever begin
			@(negedge CLK);
			if (mem_arvalid) begin
				mem_line = mem_araddr;
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge CLK);
				@(posedge CLK);
				#2 mem_arready = 1'b1;
				// Address handshake on this edge
				@(posedge CLK);
				#2 mem_arready = 1'b0;
				mem_rvalid = 1'b1;
				for (int b = 0; b < l2c_pkg::BEATS; b++) begin
					mem_rdata = expected_beat(mem_line, b);
					mem_rlast = (b == l2c_pkg::BEATS - 1);
					// rready sampled at the falling edge, stable until the next rise
					do begin
						@(negedge CLK);
						xfer = mem_rready;
						@(posedge CLK);
						#2;
					end while (!xfer);
				end
				mem_rvalid = 1'b0;
				mem_rlast  = 1'b0;
			end
		end
	end

	// Checks one client port at the falling edge
	task automatic check_port(input int p, input logic rvalid, input logic rready,
			input logic rlast, input logic [l2c_pkg::DATA_W-1:0] rdata);
		logic [l2c_pkg::DATA_W-1:0] exp;
		logic exp_last;
		string pname;
		pname = (p == 0) ? "il1" : "dl1";
		// A stalled beat must not move
		if (held_stall[p]) begin
			assert (rdata == held_data[p]) else begin
				data_errors++;
				$display("error %s_rdata changed in stall: was %h now %h",
				         pname, held_data[p], rdata);
			end
			assert (rlast == held_last[p]) else begin
				data_errors++;
				$display("error %s_rlast changed in stall: was %h now %h",
				         pname, held_last[p], rlast);
			end
		end
		held_stall[p] = rvalid && !rready;
		held_data[p]  = rdata;
		held_last[p]  = rlast;
		if (rvalid && rready) begin
			exp = expected_beat(cur_addr[p], beat_cnt[p]);
			exp_last = (beat_cnt[p] == l2c_pkg::BEATS - 1);
			assert (rdata == exp) else begin
				data_errors++;
				$display("error %s_rdata beat %0d: got %h expected %h",
				         pname, beat_cnt[p], rdata, exp);
			end
			assert (rlast == exp_last) else begin
				data_errors++;
				$display("error %s_rlast beat %0d: got %h expected %h",
				         pname, beat_cnt[p], rlast, exp_last);
			end
			beats_checked++;
			if (beat_cnt[p] == l2c_pkg::BEATS - 1) begin
				beat_cnt[p] = 0;
				lines_done[p]++;
			end else begin
				beat_cnt[p]++;
			end
		end
	endtask

	always @(negedge CLK) begin
		if (!reset) begin
			check_port(0, il1_rvalid, il1_rready, il1_rlast, il1_rdata);
			check_port(1, dl1_rvalid, dl1_rready, dl1_rlast, dl1_rdata);
		end
	end

	// One line read, returns once the last beat has transferred
	task automatic issue_read(input int p, input logic [l2c_pkg::ADDR_W-1:0] addr,
			output bit saw_mem, output int wait_n, output int ack_cycle);
		int target;
		bit acked;
		target = lines_done[p] + 1;
		cur_addr[p] = addr;
		req_count++;
		saw_mem = 1'b0;
		wait_n = 0;
		ack_cycle = 0;
		acked = 1'b0;
		if (p == 0) begin
			il1_araddr  = addr;
			il1_arvalid = 1'b1;
		end else begin
			dl1_araddr  = addr;
			dl1_arvalid = 1'b1;
		end
		while (!acked) begin
			@(negedge CLK);
			wait_n++;
			if (mem_arvalid)
				saw_mem = 1'b1;
			acked = (p == 0) ? il1_arready : dl1_arready;
			if (acked)
				ack_cycle = cycle;
			@(posedge CLK);
			#2;
		end
		if (p == 0)
			il1_arvalid = 1'b0;
		else
			dl1_arvalid = 1'b0;
		// Beat 0 is due one cycle after the accept
		@(negedge CLK);
		assert ((p == 0) ? il1_rvalid : dl1_rvalid) else begin
			flow_errors++;
			$display("port %0d rvalid did not rise one cycle after arready", p);
		end
		do begin
			@(posedge CLK);
		end while (lines_done[p] != target);
		#2;
	endtask

	task automatic check_hit_timing(input int p, input bit saw_mem, input int wait_n);
		assert (!saw_mem) else begin
			flow_errors++;
			$display("port %0d read of a cached line went to memory", p);
		end
		assert (wait_n == 2) else begin
			flow_errors++;
			$display("port %0d arready came %0d cycles after the request, not 2", p, wait_n);
		end
	endtask

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [l2c_pkg::ADDR_W-1:0] a_line;
		bit saw_i;
		bit saw_d;
		int wait_i;
		int wait_d;
		int ack_i;
		int ack_d;
		int port;
		reset       = 1'b1;
		il1_araddr  = '0;
		il1_arvalid = 1'b0;
		il1_rready  = 1'b0;
		dl1_araddr  = '0;
		dl1_arvalid = 1'b0;
		dl1_rready  = 1'b0;
		mem_arready = 1'b0;
		mem_rdata   = '0;
		mem_rlast   = 1'b0;
		mem_rvalid  = 1'b0;
		l2c_fence   = 1'b0;
		repeat (10) @(posedge CLK);
		#2 reset = 1'b0;
		@(posedge CLK);
		#2;

		// Cold read misses and refills
		issue_read(0, LINE_A, saw_i, wait_i, ack_i);
		assert (saw_i) else begin
			flow_errors++;
			$display("first read of line %h did not request memory", LINE_A);
		end

		// Rereads from both ports hit
		issue_read(0, LINE_A, saw_i, wait_i, ack_i);
		check_hit_timing(0, saw_i, wait_i);
		issue_read(1, LINE_A, saw_d, wait_d, ack_d);
		check_hit_timing(1, saw_d, wait_d);

		// Both ports at once, instruction port first
		fork
			issue_read(0, LINE_B, saw_i, wait_i, ack_i);
			issue_read(1, LINE_C, saw_d, wait_d, ack_d);
		join
		assert (ack_i < ack_d) else begin
			flow_errors++;
			$display("data port was accepted before the instruction port");
		end

		// Six lines in set 3 overflow four ways
		for (int i = 0; i < 6; i++)
			issue_read(i % 2, (32'(i + 16) << 8) | 32'h60, saw_i, wait_i, ack_i);
		for (int i = 0; i < 6; i++)
			issue_read((i + 1) % 2, (32'(i + 16) << 8) | 32'h60, saw_i, wait_i, ack_i);

		// Still cached before the fence, refilled after it
		issue_read(1, LINE_A, saw_d, wait_d, ack_d);
		check_hit_timing(1, saw_d, wait_d);
		l2c_fence = 1'b1;
		@(posedge CLK);
		#2 l2c_fence = 1'b0;
		repeat (3) @(posedge CLK);
		#2;
		issue_read(0, LINE_A, saw_i, wait_i, ack_i);
		assert (saw_i) else begin
			flow_errors++;
			$display("read after fence was served without a refill");
		end

		// Random lines over a small tag range, all sets
		for (int i = 0; i < 20; i++) begin
			a_line = $random(seed) & 32'h0000_03E0;
			port = $unsigned($random(seed)) % 2;
			issue_read(port, a_line, saw_i, wait_i, ack_i);
		end

		repeat (4) @(posedge CLK);
		assert (beats_checked == req_count * l2c_pkg::BEATS) else begin
			flow_errors++;
			$display("only %0d beats seen for %0d requests", beats_checked, req_count);
		end
		$display("data errors %0d, flow errors %0d, beats checked %0d",
		         data_errors, flow_errors, beats_checked);
		if (data_errors == 0 && flow_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
l2c_pkg.sv
l2c_way.sv
l2c_victim_sel.sv
l2c_hit_mux.sv
l2c_ctrl.sv
l2_cache.sv
tb_l2_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build the L2 cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_l2_cache \
	-f filelist.f \
	-o sim_l2_cache

./obj_dir/sim_l2_cache | tee sim.log

# The log decides the result
if grep -q "ALL TESTS PASSED" sim.log; then
	echo "run_sim: pass"
else
	echo "run_sim: fail, see sim.log"
	exit 1
fi
